// ==== asg_pkg.sv ====
// shared widths, register map and types of the two-channel waveform generator
// read pointers are unsigned fixed point with FRAC_W fraction bits
// register offsets are relative to window 0 (address bits 19..16 zero)

package asg_pkg;

  // widths -----------------------------------------
  localparam int BUF_AW = 10;               // 1024 samples per channel
  localparam int DAC_W  = 14;
  localparam int FRAC_W = 16;
  localparam int PNT_W  = BUF_AW + FRAC_W;  // integer index plus fraction

  typedef logic signed [DAC_W-1:0] sample_t;
  typedef logic [PNT_W-1:0]        pnt_t;
  typedef logic [BUF_AW-1:0]       buf_addr_t;
  typedef logic [31:0]             bus_word_t;

  localparam sample_t AMP_UNITY = 14'h2000;  // unity gain in Q1.13

  // register map -----------------------------------
  localparam logic [15:0] REG_CTRL    = 16'h0000;
  localparam logic [15:0] REG_A_AMPDC = 16'h0004;
  localparam logic [15:0] REG_A_SIZE  = 16'h0008;
  localparam logic [15:0] REG_A_OFS   = 16'h000C;
  localparam logic [15:0] REG_A_STEP  = 16'h0010;
  localparam logic [15:0] REG_B_AMPDC = 16'h0024;
  localparam logic [15:0] REG_B_SIZE  = 16'h0028;
  localparam logic [15:0] REG_B_OFS   = 16'h002C;
  localparam logic [15:0] REG_B_STEP  = 16'h0030;
  localparam logic [15:0] REG_A_PNT   = 16'h0060;
  localparam logic [15:0] REG_B_PNT   = 16'h0064;

  // sample buffer windows on address bits 19..16
  localparam logic [3:0] WIN_A = 4'd1;
  localparam logic [3:0] WIN_B = 4'd2;

  localparam int CH_B_SHIFT = 16;  // channel B control bits in REG_CTRL

  // sequencer ----------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } seq_state_t;

endpackage

// ==== asg_cfg_if.sv ====
`timescale 1ns/10ps
// settings of one channel from the register bank, pointer index back to it
// trig is high for a single cycle per software trigger

interface asg_cfg_if;

  asg_pkg::sample_t   amp;   // unsigned gain, AMP_UNITY is one
  asg_pkg::sample_t   dc;    // signed output offset
  asg_pkg::pnt_t      size;  // table length minus one lsb
  asg_pkg::pnt_t      ofs;   // start position
  asg_pkg::pnt_t      step;  // advance per cycle
  logic               wrap;
  logic               rst;
  logic               zero;
  logic               trig;
  asg_pkg::buf_addr_t rpnt;  // integer part of the read pointer

  modport regs (
    output amp, dc, size, ofs, step, wrap, rst, zero, trig,
    input  rpnt
  );

  modport ch (
    input  amp, dc, size, ofs, step, wrap, rst, zero, trig,
    output rpnt
  );

endinterface

// ==== asg_buf.sv ====
`timescale 1ns/10ps
// sample RAM of one channel with one write and two synchronous read ports
// contents are not cleared by reset

module asg_buf (
  input  logic               sys_clk,
  input  logic               we_i,
  input  asg_pkg::buf_addr_t waddr_i,
  input  asg_pkg::sample_t   wdata_i,
  input  asg_pkg::buf_addr_t raddr_a_i,  // bus readback
  output asg_pkg::sample_t   rdata_a_o,
  input  asg_pkg::buf_addr_t raddr_b_i,  // playback
  output asg_pkg::sample_t   rdata_b_o
);

  asg_pkg::sample_t mem [2**asg_pkg::BUF_AW];

  always_ff @(posedge sys_clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    rdata_a_o <= mem[raddr_a_i];
    rdata_b_o <= mem[raddr_b_i];
  end

endmodule

// ==== asg_scale.sv ====
`timescale 1ns/10ps
// output stage computing sample * amp / 2^13 + dc, saturated to 14 bits
// amp is unsigned, the shift rounds toward minus infinity

module asg_scale (
  input  logic             sys_clk,
  input  logic             sys_rstn,
  input  asg_pkg::sample_t sample_i,
  input  asg_pkg::sample_t amp_i,
  input  asg_pkg::sample_t dc_i,
  input  logic             zero_i,
  output asg_pkg::sample_t dac_o
);

  logic signed [2*asg_pkg::DAC_W:0]   prod;  // 14 x 15 bit signed
  logic signed [asg_pkg::DAC_W+2:0]   sum;
  logic                               ovf;

  assign prod = sample_i * $signed({1'b0, amp_i});
  assign sum  = $signed(prod[2*asg_pkg::DAC_W:asg_pkg::DAC_W-1]) + dc_i;
  // fits in 14 bits only if the top bits all match the sign
  assign ovf  = (sum[asg_pkg::DAC_W+2:asg_pkg::DAC_W-1] != {4{sum[asg_pkg::DAC_W+2]}});

  always_ff @(posedge sys_clk) begin
    if (!sys_rstn) begin
      dac_o <= '0;
    end else if (zero_i) begin
      dac_o <= '0;
    end else if (ovf) begin
      dac_o <= {sum[asg_pkg::DAC_W+2], {(asg_pkg::DAC_W-1){!sum[asg_pkg::DAC_W+2]}}};
    end else begin
      dac_o <= sum[asg_pkg::DAC_W-1:0];
    end
  end

endmodule

// ==== asg_ch.sv ====
`timescale 1ns/10ps
// one playback channel with pointer sequencer, sample RAM and scaler
// in wrap mode step must not exceed size plus one lsb
// pointer to DAC latency is two cycles

module asg_ch (
  input  logic               sys_clk,
  input  logic               sys_rstn,
  asg_cfg_if.ch              cfg,
  input  logic               buf_we_i,
  input  asg_pkg::buf_addr_t buf_addr_i,
  input  asg_pkg::sample_t   buf_wdata_i,
  output asg_pkg::sample_t   buf_rdata_o,
  output asg_pkg::sample_t   dac_o
);

  asg_pkg::seq_state_t     state;
  asg_pkg::pnt_t           pnt;
  logic [asg_pkg::PNT_W:0] pnt_sum;   // extra bit so the compare cannot overflow
  logic [asg_pkg::PNT_W:0] pnt_wrap;
  asg_pkg::buf_addr_t      rd_idx;
  asg_pkg::sample_t        smp;
  logic                    done_q;    // ST_DONE aligned to the RAM latency

  assign pnt_sum  = {1'b0, pnt} + {1'b0, cfg.step};
  assign pnt_wrap = pnt_sum - {1'b0, cfg.size} - 1'b1;  // minus (size + 1 lsb)
  assign rd_idx   = pnt[asg_pkg::PNT_W-1:asg_pkg::FRAC_W];
  assign cfg.rpnt = rd_idx;

  // sequencer ----------------------------------------
  always_ff @(posedge sys_clk) begin
    if (!sys_rstn) begin
      state  <= asg_pkg::ST_IDLE;
      pnt    <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= (state == asg_pkg::ST_DONE);
      if (cfg.rst) begin
        state <= asg_pkg::ST_IDLE;  // parked at ofs, triggers ignored
        pnt   <= cfg.ofs;
      end else if (cfg.trig) begin
        state <= asg_pkg::ST_RUN;   // retrigger restarts from any state
        pnt   <= cfg.ofs;
      end else if (state == asg_pkg::ST_RUN) begin
        if (pnt_sum <= {1'b0, cfg.size}) begin
          pnt <= pnt_sum[asg_pkg::PNT_W-1:0];
        end else if (cfg.wrap) begin
          pnt <= pnt_wrap[asg_pkg::PNT_W-1:0];
        end else begin
          state <= asg_pkg::ST_DONE;  // pointer keeps the last index
        end
      end
    end
  end

  asg_buf u_buf (
    .sys_clk   (sys_clk),
    .we_i      (buf_we_i),
    .waddr_i   (buf_addr_i),
    .wdata_i   (buf_wdata_i),
    .raddr_a_i (buf_addr_i),
    .rdata_a_o (buf_rdata_o),
    .raddr_b_i (rd_idx),
    .rdata_b_o (smp)
  );

  asg_scale u_scale (
    .sys_clk  (sys_clk),
    .sys_rstn (sys_rstn),
    .sample_i (smp),
    .amp_i    (cfg.amp),
    .dc_i     (cfg.dc),
    .zero_i   (cfg.zero || done_q),
    .dac_o    (dac_o)
  );

endmodule

// ==== asg_regs.sv ====
`timescale 1ns/10ps
// bus decoder and register bank for both channels
// window 0 holds registers, windows 1 and 2 the sample buffers, one word per sample
// master must hold address and data for the strobe and wait for ack
// buffer reads ack three cycles after the strobe, all else one

module asg_regs (
  input  logic                sys_clk,
  input  logic                sys_rstn,
  input  asg_pkg::bus_word_t  sys_addr_i,
  input  asg_pkg::bus_word_t  sys_wdata_i,
  input  logic                sys_wen_i,
  input  logic                sys_ren_i,
  output asg_pkg::bus_word_t  sys_rdata_o,
  output logic                sys_ack_o,
  output logic                buf_a_we_o,
  output logic                buf_b_we_o,
  output asg_pkg::buf_addr_t  buf_addr_o,
  output asg_pkg::sample_t    buf_wdata_o,
  input  asg_pkg::sample_t    buf_a_rdata_i,
  input  asg_pkg::sample_t    buf_b_rdata_i,
  asg_cfg_if.regs             cfg_a,
  asg_cfg_if.regs             cfg_b
);

  logic [3:0]         win;
  logic [15:0]        reg_ofs;
  logic               reg_sel;
  logic               reg_wr;
  logic [1:0]         trig_wr;    // trigger bit seen, one cycle before the pulse
  logic [1:0]         ren_dly;
  logic [3:0]         rd_win_q;
  asg_pkg::bus_word_t reg_rdata;
  asg_pkg::sample_t   buf_rdata;

  assign win     = sys_addr_i[19:16];
  assign reg_ofs = sys_addr_i[15:0];
  assign reg_sel = (win == 4'd0);
  assign reg_wr  = sys_wen_i && reg_sel;

  // configuration registers --------------------------
  always_ff @(posedge sys_clk) begin
    if (!sys_rstn) begin
      cfg_a.amp  <= asg_pkg::AMP_UNITY;
      cfg_a.dc   <= '0;
      cfg_a.size <= '1;
      cfg_a.ofs  <= '0;
      cfg_a.step <= '0;
      cfg_a.wrap <= 1'b0;
      cfg_a.rst  <= 1'b0;
      cfg_a.zero <= 1'b0;
      cfg_b.amp  <= asg_pkg::AMP_UNITY;
      cfg_b.dc   <= '0;
      cfg_b.size <= '1;
      cfg_b.ofs  <= '0;
      cfg_b.step <= '0;
      cfg_b.wrap <= 1'b0;
      cfg_b.rst  <= 1'b0;
      cfg_b.zero <= 1'b0;
    end else if (reg_wr) begin
      case (reg_ofs)
        asg_pkg::REG_CTRL: begin
          cfg_a.wrap <= sys_wdata_i[4];
          cfg_a.rst  <= sys_wdata_i[5];
          cfg_a.zero <= sys_wdata_i[6];
          cfg_b.wrap <= sys_wdata_i[asg_pkg::CH_B_SHIFT+4];
          cfg_b.rst  <= sys_wdata_i[asg_pkg::CH_B_SHIFT+5];
          cfg_b.zero <= sys_wdata_i[asg_pkg::CH_B_SHIFT+6];
        end
        asg_pkg::REG_A_AMPDC: begin
          cfg_a.amp <= sys_wdata_i[13:0];
          cfg_a.dc  <= sys_wdata_i[29:16];
        end
        asg_pkg::REG_A_SIZE: cfg_a.size <= sys_wdata_i[asg_pkg::PNT_W-1:0];
        asg_pkg::REG_A_OFS:  cfg_a.ofs  <= sys_wdata_i[asg_pkg::PNT_W-1:0];
        asg_pkg::REG_A_STEP: cfg_a.step <= sys_wdata_i[asg_pkg::PNT_W-1:0];
        asg_pkg::REG_B_AMPDC: begin
          cfg_b.amp <= sys_wdata_i[13:0];
          cfg_b.dc  <= sys_wdata_i[29:16];
        end
        asg_pkg::REG_B_SIZE: cfg_b.size <= sys_wdata_i[asg_pkg::PNT_W-1:0];
        asg_pkg::REG_B_OFS:  cfg_b.ofs  <= sys_wdata_i[asg_pkg::PNT_W-1:0];
        asg_pkg::REG_B_STEP: cfg_b.step <= sys_wdata_i[asg_pkg::PNT_W-1:0];
        default: ;
      endcase
    end
  end

  // strobes, triggers and ack ------------------------
  always_ff @(posedge sys_clk) begin
    if (!sys_rstn) begin
      trig_wr    <= '0;
      cfg_a.trig <= 1'b0;
      cfg_b.trig <= 1'b0;
      buf_a_we_o <= 1'b0;
      buf_b_we_o <= 1'b0;
      ren_dly    <= '0;
      sys_ack_o  <= 1'b0;
    end else begin
      trig_wr[0] <= reg_wr && (reg_ofs == asg_pkg::REG_CTRL) && sys_wdata_i[0];
      trig_wr[1] <= reg_wr && (reg_ofs == asg_pkg::REG_CTRL)
                    && sys_wdata_i[asg_pkg::CH_B_SHIFT];
      cfg_a.trig <= trig_wr[0];
      cfg_b.trig <= trig_wr[1];
      buf_a_we_o <= sys_wen_i && (win == asg_pkg::WIN_A);
      buf_b_we_o <= sys_wen_i && (win == asg_pkg::WIN_B);
      ren_dly    <= {ren_dly[0], sys_ren_i && !reg_sel};  // RAM read in flight
      sys_ack_o  <= sys_wen_i || (sys_ren_i && reg_sel) || ren_dly[1];
    end
  end

  // shared buffer address, held until the next strobe
  always_ff @(posedge sys_clk) begin
    if (sys_wen_i || sys_ren_i) begin
      buf_addr_o  <= sys_addr_i[asg_pkg::BUF_AW+1:2];
      buf_wdata_o <= sys_wdata_i[asg_pkg::DAC_W-1:0];
      rd_win_q    <= win;
    end
  end

  // readback -----------------------------------------
  assign buf_rdata = (rd_win_q == asg_pkg::WIN_A) ? buf_a_rdata_i : buf_b_rdata_i;

  always_comb begin
    reg_rdata = '0;
    case (reg_ofs)
      asg_pkg::REG_CTRL: begin
        reg_rdata[6:4] = {cfg_a.zero, cfg_a.rst, cfg_a.wrap};  // trigger reads 0
        reg_rdata[asg_pkg::CH_B_SHIFT+4 +: 3] = {cfg_b.zero, cfg_b.rst, cfg_b.wrap};
      end
      asg_pkg::REG_A_AMPDC: reg_rdata = {2'b00, cfg_a.dc, 2'b00, cfg_a.amp};
      asg_pkg::REG_A_SIZE:  reg_rdata[asg_pkg::PNT_W-1:0] = cfg_a.size;
      asg_pkg::REG_A_OFS:   reg_rdata[asg_pkg::PNT_W-1:0] = cfg_a.ofs;
      asg_pkg::REG_A_STEP:  reg_rdata[asg_pkg::PNT_W-1:0] = cfg_a.step;
      asg_pkg::REG_B_AMPDC: reg_rdata = {2'b00, cfg_b.dc, 2'b00, cfg_b.amp};
      asg_pkg::REG_B_SIZE:  reg_rdata[asg_pkg::PNT_W-1:0] = cfg_b.size;
      asg_pkg::REG_B_OFS:   reg_rdata[asg_pkg::PNT_W-1:0] = cfg_b.ofs;
      asg_pkg::REG_B_STEP:  reg_rdata[asg_pkg::PNT_W-1:0] = cfg_b.step;
      asg_pkg::REG_A_PNT:   reg_rdata[asg_pkg::BUF_AW+1:2] = cfg_a.rpnt;  // byte address
      asg_pkg::REG_B_PNT:   reg_rdata[asg_pkg::BUF_AW+1:2] = cfg_b.rpnt;
      default: ;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (ren_dly[1]) begin
      sys_rdata_o <= {{(32-asg_pkg::DAC_W){1'b0}}, buf_rdata};
    end else if (sys_ren_i) begin
      sys_rdata_o <= reg_rdata;
    end
  end

endmodule

// ==== asg_top.sv ====
`timescale 1ns/10ps
// two-channel arbitrary waveform generator on a single clock
// trig_out_o follows the software trigger of channel A only

module asg_top (
  input  logic               sys_clk,
  input  logic               sys_rstn,
  input  asg_pkg::bus_word_t sys_addr_i,
  input  asg_pkg::bus_word_t sys_wdata_i,
  input  logic               sys_wen_i,
  input  logic               sys_ren_i,
  output asg_pkg::bus_word_t sys_rdata_o,
  output logic               sys_ack_o,
  output asg_pkg::sample_t   dac_a_o,
  output asg_pkg::sample_t   dac_b_o,
  output logic               trig_out_o
);

  logic               buf_a_we;
  logic               buf_b_we;
  asg_pkg::buf_addr_t buf_addr;   // shared by both RAMs
  asg_pkg::sample_t   buf_wdata;
  asg_pkg::sample_t   buf_a_rdata;
  asg_pkg::sample_t   buf_b_rdata;

  asg_cfg_if cfg_a ();
  asg_cfg_if cfg_b ();

  asg_regs u_regs (
    .sys_clk       (sys_clk),
    .sys_rstn      (sys_rstn),
    .sys_addr_i    (sys_addr_i),
    .sys_wdata_i   (sys_wdata_i),
    .sys_wen_i     (sys_wen_i),
    .sys_ren_i     (sys_ren_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .buf_a_we_o    (buf_a_we),
    .buf_b_we_o    (buf_b_we),
    .buf_addr_o    (buf_addr),
    .buf_wdata_o   (buf_wdata),
    .buf_a_rdata_i (buf_a_rdata),
    .buf_b_rdata_i (buf_b_rdata),
    .cfg_a         (cfg_a.regs),
    .cfg_b         (cfg_b.regs)
  );

  asg_ch u_ch_a (
    .sys_clk     (sys_clk),
    .sys_rstn    (sys_rstn),
    .cfg         (cfg_a.ch),
    .buf_we_i    (buf_a_we),
    .buf_addr_i  (buf_addr),
    .buf_wdata_i (buf_wdata),
    .buf_rdata_o (buf_a_rdata),
    .dac_o       (dac_a_o)
  );

  asg_ch u_ch_b (
    .sys_clk     (sys_clk),
    .sys_rstn    (sys_rstn),
    .cfg         (cfg_b.ch),
    .buf_we_i    (buf_b_we),
    .buf_addr_i  (buf_addr),
    .buf_wdata_i (buf_wdata),
    .buf_rdata_o (buf_b_rdata),
    .dac_o       (dac_b_o)
  );

  assign trig_out_o = cfg_a.trig;

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/10ps
// testbench clock and synchronous active-low reset
// reset is released DRIVE_DLY after the last reset edge

module tb_clkgen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 16,
  parameter int DRIVE_DLY  = 10
) (
  output logic sys_clk_o,
  output logic sys_rstn_o
);

  initial begin
    sys_clk_o = 1'b0;
    forever #(PERIOD_NS / 2) sys_clk_o = ~sys_clk_o;
  end

  initial begin
    sys_rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge sys_clk_o);
    #(DRIVE_DLY);
    sys_rstn_o = 1'b1;  // first edge out of reset is the next one
  end

endmodule

// ==== tb_asg.sv ====
`timescale 1ns/10ps
// testbench top that replays the command lines of asg_golden.txt against the DUT
// the golden file is opened relative to the directory the simulation runs in
// inputs change 10 ns after the rising edge, outputs are sampled there too

module tb_asg;

  localparam int    DRIVE_DLY = 10;  // ns after the rising edge
  localparam int    ACK_LIMIT = 16;  // cycles to wait for ack
  localparam string GOLDEN    = "asg_golden.txt";

  logic               sys_clk;
  logic               sys_rstn;
  asg_pkg::bus_word_t sys_addr_i;
  asg_pkg::bus_word_t sys_wdata_i;
  logic               sys_wen_i;
  logic               sys_ren_i;
  asg_pkg::bus_word_t sys_rdata_o;
  logic               sys_ack_o;
  asg_pkg::sample_t   dac_a_o;
  asg_pkg::sample_t   dac_b_o;
  logic               trig_out_o;

  int wd_cycles = 0;  // set once the golden lines are counted
  int n_checks  = 0;
  int n_errors  = 0;
  int dac_exp[$];     // expected DAC values of one run line

  tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(16), .DRIVE_DLY(DRIVE_DLY)) u_clkgen (
    .sys_clk_o  (sys_clk),
    .sys_rstn_o (sys_rstn)
  );

  asg_top asg_top_inst (
    .sys_clk     (sys_clk),
    .sys_rstn    (sys_rstn),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o),
    .trig_out_o  (trig_out_o)
  );

  // helpers ------------------------------------------
  task automatic next_cycle();
    @(posedge sys_clk);
    #(DRIVE_DLY);
  endtask

  task automatic check_value(input string what, input int got, input int exp);
    n_checks++;
    assert (got == exp) else begin
      n_errors++;
      $display("** Error at %0t: %s is 0x%0h (%0d), expected 0x%0h (%0d)",
               $time, what, got, got, exp, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic wait_ack(output int lat);
    lat = 1;
    while (!sys_ack_o && lat < ACK_LIMIT) begin
      next_cycle();
      lat++;
    end
    if (!sys_ack_o) begin
      $display("no ack from the DUT within %0d cycles of the strobe", ACK_LIMIT);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic bus_write(input asg_pkg::bus_word_t addr, input asg_pkg::bus_word_t data);
    int lat;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    next_cycle();       // strobe edge has passed
    sys_wen_i = 1'b0;
    wait_ack(lat);
    check_value($sformatf("write ack latency at 0x%h", addr), lat, 1);
  endtask

  task automatic bus_read(input asg_pkg::bus_word_t addr, input asg_pkg::bus_word_t exp,
                          input int exp_lat);
    int lat;
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    next_cycle();
    sys_ren_i = 1'b0;
    wait_ack(lat);
    check_value($sformatf("read ack latency at 0x%h", addr), lat, exp_lat);
    check_value($sformatf("read data at 0x%h", addr), sys_rdata_o, exp);
  endtask

  // control write at edge N, trig_out in the cycle after N+1, DAC from N+4
  task automatic run_check(input int ch, input asg_pkg::bus_word_t ctrl);
    int k;
    int dac;
    bus_write({16'h0000, asg_pkg::REG_CTRL}, ctrl);  // now just after edge N
    for (k = 0; k < 4 + dac_exp.size(); k++) begin
      check_value("trig_out_o", trig_out_o, (k == 1) ? int'(ctrl[0]) : 0);
      if (k >= 4) begin
        dac = (ch == 0) ? dac_a_o : dac_b_o;
        check_value($sformatf("dac of channel %0d, sample %0d", ch, k - 4), dac, dac_exp[k-4]);
      end
      next_cycle();
    end
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != "\n" && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic fields_ok(input int code, input int want);
    if (code != want) begin
      $display("malformed line in %s, read %0d of %0d fields", GOLDEN, code, want);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // golden replay ------------------------------------
  initial begin : replay
    int                 fd;
    int                 c;
    int                 code;
    int                 lines;
    int                 ch;
    int                 n;
    int                 lat;
    int                 v;
    asg_pkg::bus_word_t addr;
    asg_pkg::bus_word_t data;
    $timeformat(-9, 0, " ns", 0);
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0) begin
      $display("cannot open %s", GOLDEN);
      $display("Simulation failed");
      $fatal(1);
    end
    lines = 0;
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "\n") lines++;
      c = $fgetc(fd);
    end
    $fclose(fd);
    wd_cycles = lines * 100 + 1000;
    fd = $fopen(GOLDEN, "r");
    wait (sys_rstn === 1'b1);
    next_cycle();
    c = $fgetc(fd);
    while (c != -1) begin
      case (c)
        " ", "\t", "\r", "\n": ;
        "#": skip_line(fd);
        "W": begin
          code = $fscanf(fd, "%h %h", addr, data);
          fields_ok(code, 2);
          bus_write(addr, data);
        end
        "R": begin
          code = $fscanf(fd, "%h %h %d", addr, data, lat);
          fields_ok(code, 3);
          bus_read(addr, data, lat);
        end
        "X": begin
          code = $fscanf(fd, "%d %h %d", ch, data, n);
          fields_ok(code, 3);
          dac_exp.delete();
          repeat (n) begin
            code = $fscanf(fd, "%d", v);
            fields_ok(code, 1);
            dac_exp.push_back(v);
          end
          run_check(ch, data);
        end
        default: begin
          $display("unknown command character '%c' in %s", c[7:0], GOLDEN);
          $display("Simulation failed");
          $fatal(1);
        end
      endcase
      c = $fgetc(fd);
    end
    $fclose(fd);
    if (n_errors == 0 && n_checks > 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d errors in %0d checks", n_errors, n_checks);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin : watchdog
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge sys_clk);
    $display("run did not finish within %0d cycles", wd_cycles);
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

// ==== asg_golden.txt ====
# W addr data | R addr data ack_cycles | X ch ctrl n dac0 .. dacn-1 (DAC from N+4)
# addr, data and ctrl in hex, the rest decimal
# reset values and register readback
R 00000004 00002000 1
R 00000008 03ffffff 1
R 00000060 00000000 1
W 00000030 00012345
R 00000030 00012345 1
# sample tables, A at window 1 and B at window 2
W 00010000 00000064
W 00010004 000000c8
W 00010008 0000012c
W 0001000c 00000190
W 00020000 000003e8
W 00020004 000007d0
W 00020008 00000bb8
W 0002000c 00000fa0
W 00020010 00001fff
R 00010000 00000064 3
R 00020000 000003e8 3
R 0001000c 00000190 3
R 00020010 00001fff 3
# channel A wrap, four samples, step one
W 00000008 0003ffff
W 00000010 00010000
X 0 00000011 12 100 200 300 400 100 200 300 400 100 200 300 400
# channel B step one half, amp 0x1000, dc 100
W 00000028 0003ffff
W 00000030 00008000
W 00000024 00641000
X 1 00110010 10 600 600 1100 1100 1600 1600 2100 2100 600 600
# full-scale sample with dc 5000 saturates
W 00000024 13881000
W 00000028 0004ffff
W 00000030 00000000
W 0000002c 00040000
X 1 00110010 4 8191 8191 8191 8191
# channel A one-shot from index two
W 0000000c 00020000
X 0 00000001 6 300 400 0 0 0 0
R 00000060 0000000c 1
# zero on B, then rst on A holds the sample at ofs
X 1 00400000 4 0 0 0 0
W 0000000c 00010000
X 0 00000021 6 200 200 200 200 200 200
R 00000060 00000004 1
R 00000000 00000020 1

// ==== tb.f ====
asg_pkg.sv
asg_cfg_if.sv
asg_buf.sv
asg_scale.sv
asg_ch.sv
asg_regs.sv
asg_top.sv
tb_clkgen.sv
tb_asg.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_asg
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
